// ==== design/hazardPkg.sv ====
`default_nettype none

package hazardPkg;

    localparam int T_WIDTH = 3;
    localparam logic [T_WIDTH-1:0] TUSE_INF = 3'd7;   // Operand never read

    // Major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_JAL = 6'h03;
    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_ORI = 6'h0d;
    localparam logic [5:0] OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;

    // SPECIAL funct codes
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_JR = 6'h08;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_MTLO = 6'h13;
    localparam logic [5:0] FN_MULT = 6'h18;
    localparam logic [5:0] FN_DIV = 6'h1a;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;

    localparam logic [4:0] REG_RA = 5'd31;            // JAL link register

    // Multiplier occupancy in cycles
    localparam int MD_CNT_WIDTH = 4;
    localparam logic [MD_CNT_WIDTH-1:0] MULT_CYCLES = 4'd5;
    localparam logic [MD_CNT_WIDTH-1:0] DIV_CYCLES = 4'd10;

    typedef enum logic [3:0] {
        K_NOP, K_ADDU, K_SUBU, K_SLL, K_ORI, K_LUI, K_LW, K_SW,
        K_BEQ, K_JAL, K_JR, K_MULT, K_DIV, K_MFLO, K_MTLO
    } instrKind;

    typedef enum logic [2:0] {
        CALC_R, CALC_I, MEM_READ, MEM_WRITE, BRANCH, JUMP, MULTDIV, NONE
    } funcClass;

    typedef enum logic [1:0] {
        KCTRL_NONE, KCTRL_KTEXT, KCTRL_ERET
    } kCtrl;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFields;

    // Same 32-bit word, R-type or I-type view
    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    typedef struct packed {
        logic [4:0]         rsAddr;
        logic [4:0]         rtAddr;
        logic [T_WIDTH-1:0] tuseRs;
        logic [T_WIDTH-1:0] tuseRt;
        logic [T_WIDTH-1:0] tnew;
        logic [4:0]         writeAddr;
        instrKind           kind;
        funcClass           fClass;
    } timingInfo;

    typedef struct packed {
        logic               valid;
        logic [31:0]        pc;
        instrKind           kind;
        funcClass           fClass;
        logic [4:0]         writeAddr;
        logic [T_WIDTH-1:0] tnew;
    } stageRec;

    localparam stageRec BUBBLE_REC = '0;              // Invalid NOP record

    typedef struct packed {
        logic stallPc;
        logic stallId;
        logic clrId;
        logic clrEx;
        logic clrMem;
        logic clrWb;
    } pipeCtrl;

endpackage

`default_nettype wire

// ==== design/instrClassifier.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrClassifier (
    input  hazardPkg::instrWord instr,
    output hazardPkg::instrKind kind,
    output hazardPkg::funcClass fClass
);

    always_comb begin
        kind = hazardPkg::K_NOP;
        case (instr.i.opcode)
            hazardPkg::OP_SPECIAL: begin
                case (instr.r.funct)
                    hazardPkg::FN_ADDU: kind = hazardPkg::K_ADDU;
                    hazardPkg::FN_SUBU: kind = hazardPkg::K_SUBU;
                    hazardPkg::FN_SLL:  kind = (instr == '0) ? hazardPkg::K_NOP : hazardPkg::K_SLL;
                    hazardPkg::FN_JR:   kind = hazardPkg::K_JR;
                    hazardPkg::FN_MULT: kind = hazardPkg::K_MULT;
                    hazardPkg::FN_DIV:  kind = hazardPkg::K_DIV;
                    hazardPkg::FN_MFLO: kind = hazardPkg::K_MFLO;
                    hazardPkg::FN_MTLO: kind = hazardPkg::K_MTLO;
                    default:            kind = hazardPkg::K_NOP;
                endcase
            end
            hazardPkg::OP_ORI: kind = hazardPkg::K_ORI;
            hazardPkg::OP_LUI: kind = hazardPkg::K_LUI;
            hazardPkg::OP_LW:  kind = hazardPkg::K_LW;
            hazardPkg::OP_SW:  kind = hazardPkg::K_SW;
            hazardPkg::OP_BEQ: kind = hazardPkg::K_BEQ;
            hazardPkg::OP_JAL: kind = hazardPkg::K_JAL;
            default:           kind = hazardPkg::K_NOP;   // Unsupported word
        endcase
    end

    always_comb begin
        case (kind)
            hazardPkg::K_ADDU, hazardPkg::K_SUBU, hazardPkg::K_SLL: fClass = hazardPkg::CALC_R;
            hazardPkg::K_ORI, hazardPkg::K_LUI: fClass = hazardPkg::CALC_I;
            hazardPkg::K_LW:  fClass = hazardPkg::MEM_READ;
            hazardPkg::K_SW:  fClass = hazardPkg::MEM_WRITE;
            hazardPkg::K_BEQ: fClass = hazardPkg::BRANCH;
            hazardPkg::K_JAL, hazardPkg::K_JR: fClass = hazardPkg::JUMP;
            hazardPkg::K_MULT, hazardPkg::K_DIV,
            hazardPkg::K_MFLO, hazardPkg::K_MTLO: fClass = hazardPkg::MULTDIV;
            default: fClass = hazardPkg::NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/instrTiming.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrTiming (
    input  hazardPkg::instrWord  instr,
    output hazardPkg::timingInfo info
);

    hazardPkg::instrKind kind;
    hazardPkg::funcClass fClass;

    instrClassifier classifier (
        .instr  (instr),
        .kind   (kind),
        .fClass (fClass)
    );

    always_comb begin
        info.rsAddr = instr.i.rs;
        info.rtAddr = instr.i.rt;
        info.kind = kind;
        info.fClass = fClass;

        // Cycles until rs is needed, counted from ID
        case (kind)
            hazardPkg::K_ADDU, hazardPkg::K_SUBU, hazardPkg::K_ORI,
            hazardPkg::K_LW, hazardPkg::K_SW, hazardPkg::K_MULT,
            hazardPkg::K_DIV, hazardPkg::K_MTLO: info.tuseRs = 3'd1;
            hazardPkg::K_BEQ, hazardPkg::K_JR:   info.tuseRs = 3'd0;   // Resolved in ID
            default:                             info.tuseRs = hazardPkg::TUSE_INF;
        endcase

        case (kind)
            hazardPkg::K_ADDU, hazardPkg::K_SUBU, hazardPkg::K_SLL,
            hazardPkg::K_MULT, hazardPkg::K_DIV: info.tuseRt = 3'd1;
            hazardPkg::K_SW:  info.tuseRt = 3'd2;   // Store data only needed in MEM
            hazardPkg::K_BEQ: info.tuseRt = 3'd0;
            default:          info.tuseRt = hazardPkg::TUSE_INF;
        endcase

        // Cycles until the result can be forwarded
        case (kind)
            hazardPkg::K_ADDU, hazardPkg::K_SUBU, hazardPkg::K_SLL,
            hazardPkg::K_ORI, hazardPkg::K_MFLO: info.tnew = 3'd2;
            hazardPkg::K_LUI, hazardPkg::K_JAL:  info.tnew = 3'd1;
            hazardPkg::K_LW:                     info.tnew = 3'd3;
            default:                             info.tnew = 3'd0;
        endcase

        case (kind)
            hazardPkg::K_ADDU, hazardPkg::K_SUBU, hazardPkg::K_SLL,
            hazardPkg::K_MFLO: info.writeAddr = instr.r.rd;
            hazardPkg::K_ORI, hazardPkg::K_LUI,
            hazardPkg::K_LW:   info.writeAddr = instr.i.rt;
            hazardPkg::K_JAL:  info.writeAddr = hazardPkg::REG_RA;
            default:           info.writeAddr = 5'd0;   // No register write
        endcase
    end

endmodule

`default_nettype wire

// ==== design/stageTracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module stageTracker (
    input  logic                 clk,
    input  logic                 rst,
    input  hazardPkg::instrWord  fetchInstr,
    input  logic [31:0]          fetchPc,
    input  hazardPkg::timingInfo idInfo,
    input  hazardPkg::pipeCtrl   ctrl,
    output hazardPkg::instrWord  idInstr,
    output hazardPkg::stageRec   idRec,
    output hazardPkg::stageRec   exRec,
    output hazardPkg::stageRec   memRec,
    output hazardPkg::stageRec   wbRec
);

    logic        idValid;
    logic [31:0] idPc;

    // One stage closer to its result, never below zero
    function automatic hazardPkg::stageRec ageRec(hazardPkg::stageRec rec);
        hazardPkg::stageRec aged;
        aged = rec;
        if (rec.tnew != '0) begin
            aged.tnew = rec.tnew - 1'b1;
        end
        return aged;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || ctrl.clrId) begin
            idValid <= 1'b0;
            idInstr <= '0;             // Decodes as NOP
        end else if (!ctrl.stallId) begin
            idValid <= 1'b1;
            idInstr <= fetchInstr;
            idPc <= fetchPc;
        end
    end

    // ID record built from the live decode
    always_comb begin
        idRec.valid = idValid;
        idRec.pc = idPc;
        idRec.kind = idInfo.kind;
        idRec.fClass = idInfo.fClass;
        idRec.writeAddr = idInfo.writeAddr;
        idRec.tnew = idInfo.tnew;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exRec <= hazardPkg::BUBBLE_REC;
            memRec <= hazardPkg::BUBBLE_REC;
            wbRec <= hazardPkg::BUBBLE_REC;
        end else begin
            exRec <= ctrl.clrEx ? hazardPkg::BUBBLE_REC : ageRec(idRec);
            memRec <= ctrl.clrMem ? hazardPkg::BUBBLE_REC : ageRec(exRec);
            wbRec <= ctrl.clrWb ? hazardPkg::BUBBLE_REC : ageRec(memRec);
        end
    end

    // Hazard stall and CP0 flush are mutually exclusive
    assert property (@(posedge clk) disable iff (rst)
        !(ctrl.stallId && ctrl.clrId))
        else $error("stageTracker: stall together with ID clear");

endmodule

`default_nettype wire

// ==== design/mulDivTracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mulDivTracker (
    input  logic               clk,
    input  logic               rst,
    input  hazardPkg::stageRec exRec,
    input  logic               clrMem,   // EX occupant dropped, not moved on
    output logic               mdBusy
);

    logic [hazardPkg::MD_CNT_WIDTH-1:0] count;
    logic                               startMult;
    logic                               startDiv;

    // Starts as the instruction enters MEM
    assign startMult = exRec.valid && !clrMem && (exRec.kind == hazardPkg::K_MULT);
    assign startDiv = exRec.valid && !clrMem && (exRec.kind == hazardPkg::K_DIV);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (startMult) begin
            count <= hazardPkg::MULT_CYCLES;
        end else if (startDiv) begin
            count <= hazardPkg::DIV_CYCLES;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign mdBusy = (count != '0);

    assert property (@(posedge clk) disable iff (rst)
        count <= hazardPkg::DIV_CYCLES)
        else $error("mulDivTracker: count %0d out of range", count);

endmodule

`default_nettype wire

// ==== design/pipelineControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipelineControl (
    input  hazardPkg::timingInfo idInfo,
    input  hazardPkg::stageRec   idRec,
    input  hazardPkg::stageRec   exRec,
    input  hazardPkg::stageRec   memRec,
    input  hazardPkg::stageRec   wbRec,
    input  logic                 mdBusy,
    input  hazardPkg::kCtrl      kCtrlCp0,
    input  logic [31:0]          fetchPc,
    output hazardPkg::pipeCtrl   ctrl,
    output logic [31:0]          macroPc
);

    logic rsStall;
    logic rtStall;
    logic mdStall;
    logic hazStall;
    logic flush;

    // Producer still too far from its result
    function automatic logic lateProducer(hazardPkg::stageRec rec, logic [4:0] addr,
                                          logic [hazardPkg::T_WIDTH-1:0] tuse);
        return rec.valid && (rec.writeAddr == addr) && (rec.tnew > tuse);
    endfunction

    assign rsStall = idRec.valid && (idInfo.rsAddr != 5'd0) &&
        (lateProducer(exRec, idInfo.rsAddr, idInfo.tuseRs) ||
         lateProducer(memRec, idInfo.rsAddr, idInfo.tuseRs));
    assign rtStall = idRec.valid && (idInfo.rtAddr != 5'd0) &&
        (lateProducer(exRec, idInfo.rtAddr, idInfo.tuseRt) ||
         lateProducer(memRec, idInfo.rtAddr, idInfo.tuseRt));
    assign mdStall = idRec.valid && mdBusy && (idInfo.fClass == hazardPkg::MULTDIV);
    assign hazStall = rsStall || rtStall || mdStall;

    assign flush = (kCtrlCp0 == hazardPkg::KCTRL_KTEXT) || (kCtrlCp0 == hazardPkg::KCTRL_ERET);

    always_comb begin
        ctrl.stallPc = hazStall && !flush;   // Flush wins
        ctrl.stallId = hazStall && !flush;
        ctrl.clrId = flush;
        ctrl.clrEx = hazStall || flush;      // Bubble or flush
        ctrl.clrMem = flush;
        ctrl.clrWb = flush;
    end

    always_comb begin
        if (wbRec.valid && (wbRec.fClass == hazardPkg::BRANCH ||
                            wbRec.fClass == hazardPkg::JUMP)) begin
            macroPc = wbRec.pc;              // Delay slot reports its jump
        end else if (memRec.valid) begin
            macroPc = memRec.pc;
        end else if (exRec.valid) begin
            macroPc = exRec.pc;
        end else if (idRec.valid) begin
            macroPc = idRec.pc;
        end else begin
            macroPc = fetchPc;
        end
    end

endmodule

`default_nettype wire

// ==== design/hazardTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazardTop (
    input  logic                          clk,
    input  logic                          rst,
    input  hazardPkg::instrWord           fetchInstr,
    input  logic [31:0]                   fetchPc,
    input  hazardPkg::kCtrl               kCtrlCp0,
    output hazardPkg::pipeCtrl            ctrl,
    output logic [31:0]                   macroPc,
    output logic [hazardPkg::T_WIDTH-1:0] tnewId
);

    hazardPkg::instrWord  idInstr;
    hazardPkg::timingInfo idInfo;
    hazardPkg::stageRec   idRec;
    hazardPkg::stageRec   exRec;
    hazardPkg::stageRec   memRec;
    hazardPkg::stageRec   wbRec;
    logic                 mdBusy;

    stageTracker stages (
        .clk        (clk),
        .rst        (rst),
        .fetchInstr (fetchInstr),
        .fetchPc    (fetchPc),
        .idInfo     (idInfo),
        .ctrl       (ctrl),
        .idInstr    (idInstr),
        .idRec      (idRec),
        .exRec      (exRec),
        .memRec     (memRec),
        .wbRec      (wbRec)
    );

    instrTiming idTiming (
        .instr (idInstr),
        .info  (idInfo)
    );

    mulDivTracker mulDiv (
        .clk    (clk),
        .rst    (rst),
        .exRec  (exRec),
        .clrMem (ctrl.clrMem),
        .mdBusy (mdBusy)
    );

    pipelineControl control (
        .idInfo   (idInfo),
        .idRec    (idRec),
        .exRec    (exRec),
        .memRec   (memRec),
        .wbRec    (wbRec),
        .mdBusy   (mdBusy),
        .kCtrlCp0 (kCtrlCp0),
        .fetchPc  (fetchPc),
        .ctrl     (ctrl),
        .macroPc  (macroPc)
    );

    assign tnewId = idInfo.tnew;   // Observation only

endmodule

`default_nettype wire

// ==== dv/hazardTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazardTb;

    localparam int CYCLE_LIMIT = 400;     // Tests take about 150 cycles
    localparam logic [31:0] NOP = 32'h0000_0000;

    // MIPS encodings used by the tests
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;
    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_JAL = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_MULT = 6'h18;
    localparam logic [5:0] FN_DIV = 6'h1a;
    localparam logic [5:0] FN_MFLO = 6'h12;

    localparam int MULT_BUSY = 5;
    localparam int DIV_BUSY = 10;
    localparam int MD_GAP = 2;            // NOPs between producer and consumer

    // Order is stallPc, stallId, clrId, clrEx, clrMem, clrWb
    localparam hazardPkg::pipeCtrl IDLE_CTRL = 6'b000000;
    localparam hazardPkg::pipeCtrl STALL_CTRL = 6'b110100;
    localparam hazardPkg::pipeCtrl FLUSH_CTRL = 6'b001111;

    logic                clk;
    logic                rst;
    hazardPkg::instrWord fetchInstr;
    logic [31:0]         fetchPc;
    hazardPkg::kCtrl     kCtrlCp0;
    hazardPkg::pipeCtrl  ctrl;
    logic [31:0]         macroPc;
    logic [2:0]          tnewId;

    int cycles = 0;
    int errors = 0;
    int testErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    string curTest;
    logic [31:0] pcVar = 32'h0000_3000;
    hazardPkg::pipeCtrl lastCtrl;         // Outputs seen at the last negedge
    logic [31:0] lastMacro;
    logic [31:0] lastFetchPc;
    logic [2:0] lastTnew;

    hazardTop uut (
        .clk        (clk),
        .rst        (rst),
        .fetchInstr (fetchInstr),
        .fetchPc    (fetchPc),
        .kCtrlCp0   (kCtrlCp0),
        .ctrl       (ctrl),
        .macroPc    (macroPc),
        .tnewId     (tnewId)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt);
        return {op, rs, rt, 16'h0000};
    endfunction

    function automatic logic [4:0] randomReg();
        int unsigned pick;
        pick = $urandom % 31;
        return pick[4:0] + 5'd1;          // Never r0
    endfunction

    // Busy starts as the producer enters MEM, gap - 1 cycles before the consumer reaches ID
    function automatic int mdStallCycles(int occupancy, int gap);
        if (gap == 0 || gap - 1 >= occupancy) begin
            return 0;
        end
        return occupancy - (gap - 1);
    endfunction

    task automatic mismatch(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("FAIL %s: %s expected 0x%0h, actual 0x%0h", curTest, what, expected, actual);
        errors = errors + 1;
        testErrors = testErrors + 1;
    endtask

    task automatic beginTest(input string name);
        curTest = name;
        testErrors = 0;
        testsRun = testsRun + 1;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            $display("test %s: passed", curTest);
        end else begin
            $display("test %s: failed with %0d errors", curTest, testErrors);
            testsFailed = testsFailed + 1;
        end
    endtask

    // One fetch cycle, outputs captured at the falling edge
    task automatic present(input logic [31:0] word, input hazardPkg::kCtrl kc);
        @(posedge clk);
        fetchInstr <= word;
        fetchPc <= pcVar;
        kCtrlCp0 <= kc;
        @(negedge clk);
        lastCtrl = ctrl;
        lastMacro = macroPc;
        lastTnew = tnewId;
        lastFetchPc = fetchPc;
        if (!ctrl.stallPc) begin
            pcVar = pcVar + 32'd4;
        end
    endtask

    // Repeats the word until ID takes it
    task automatic push(input logic [31:0] word, output int stalls);
        stalls = 0;
        do begin
            present(word, hazardPkg::KCTRL_NONE);
            if (lastCtrl.stallPc) begin
                stalls = stalls + 1;
            end
            if (lastCtrl.stallPc && lastCtrl != STALL_CTRL) begin
                mismatch("stall controls", 32'(STALL_CTRL), 32'(lastCtrl));
            end
            if (!lastCtrl.stallPc && lastCtrl != IDLE_CTRL) begin
                mismatch("idle controls", 32'(IDLE_CTRL), 32'(lastCtrl));
            end
        end while (lastCtrl.stallPc);
    endtask

    task automatic drain(input int n);
        int stalls;
        repeat (n) push(NOP, stalls);
    endtask

    task automatic resetTest();
        beginTest("reset");
        @(negedge clk);
        if (ctrl != IDLE_CTRL) begin
            mismatch("pipeCtrl", 32'(IDLE_CTRL), 32'(ctrl));
        end
        if (macroPc != pcVar) begin
            mismatch("macroPc", pcVar, macroPc);
        end
        endTest();
    endtask

    task automatic loadUseTest();
        int stalls;
        beginTest("loadUse");
        push(iType(OP_LW, 5'd0, 5'd5), stalls);
        push(rType(5'd5, 5'd1, 5'd6, FN_ADDU), stalls);
        if (lastTnew != 3'd3) begin
            mismatch("LW tnew in ID", 32'd3, 32'(lastTnew));
        end
        push(NOP, stalls);                // ADDU waits behind the load
        if (stalls != 1) begin
            mismatch("ADDU after LW stall cycles", 32'd1, stalls);
        end
        drain(4);
        push(iType(OP_LW, 5'd0, 5'd5), stalls);
        push(iType(OP_SW, 5'd0, 5'd5), stalls);
        push(NOP, stalls);                // Store data needed two cycles later
        if (stalls != 0) begin
            mismatch("SW after LW stall cycles", 32'd0, stalls);
        end
        drain(4);
        endTest();
    endtask

    task automatic branchTest();
        int stalls;
        beginTest("branch");
        push(rType(5'd1, 5'd2, 5'd3, FN_ADDU), stalls);
        push(iType(OP_BEQ, 5'd3, 5'd4), stalls);
        push(NOP, stalls);
        if (stalls != 1) begin
            mismatch("BEQ after ADDU stall cycles", 32'd1, stalls);
        end
        drain(4);
        push(rType(5'd1, 5'd2, 5'd3, FN_ADDU), stalls);
        push(NOP, stalls);
        push(iType(OP_BEQ, 5'd3, 5'd4), stalls);
        push(NOP, stalls);                // ADDU result ready in MEM
        if (stalls != 0) begin
            mismatch("BEQ one slot behind ADDU stall cycles", 32'd0, stalls);
        end
        drain(4);
        endTest();
    endtask

    task automatic unrelatedTest();
        int stalls;
        logic [4:0] srcA;
        logic [4:0] srcB;
        logic [4:0] dest;
        beginTest("unrelated");
        push(iType(OP_LW, 5'd1, 5'd0), stalls);   // Load into r0
        push(rType(5'd0, 5'd0, 5'd7, FN_ADDU), stalls);
        push(NOP, stalls);
        if (stalls != 0) begin
            mismatch("r0 consumer stall cycles", 32'd0, stalls);
        end
        repeat (4) begin
            srcA = randomReg();
            srcB = randomReg();
            do begin
                dest = randomReg();
            end while (dest == srcA || dest == srcB);
            push(iType(OP_LW, 5'd0, dest), stalls);
            push(rType(srcA, srcB, 5'd0, FN_ADDU), stalls);
            push(NOP, stalls);
            if (stalls != 0) begin
                mismatch("unrelated consumer stall cycles", 32'd0, stalls);
            end
        end
        drain(4);
        endTest();
    endtask

    task automatic mulDivTest();
        int stalls;
        beginTest("mulDiv");
        push(rType(5'd1, 5'd2, 5'd0, FN_MULT), stalls);
        drain(MD_GAP);
        push(rType(5'd0, 5'd0, 5'd9, FN_MFLO), stalls);
        push(NOP, stalls);
        if (stalls != mdStallCycles(MULT_BUSY, MD_GAP)) begin
            mismatch("MFLO after MULT stall cycles", mdStallCycles(MULT_BUSY, MD_GAP), stalls);
        end
        drain(4);
        push(rType(5'd1, 5'd2, 5'd0, FN_DIV), stalls);
        drain(MD_GAP);
        push(rType(5'd0, 5'd0, 5'd9, FN_MFLO), stalls);
        push(NOP, stalls);
        if (stalls != mdStallCycles(DIV_BUSY, MD_GAP)) begin
            mismatch("MFLO after DIV stall cycles", mdStallCycles(DIV_BUSY, MD_GAP), stalls);
        end
        drain(4);
        push(rType(5'd1, 5'd2, 5'd0, FN_MULT), stalls);
        drain(MD_GAP);
        push(rType(5'd1, 5'd2, 5'd10, FN_ADDU), stalls);
        push(NOP, stalls);                // ALU op ignores the busy multiplier
        if (stalls != 0) begin
            mismatch("ADDU during busy stall cycles", 32'd0, stalls);
        end
        drain(6);
        endTest();
    endtask

    task automatic flushTest();
        int stalls;
        logic [31:0] jalPc;
        beginTest("flush");
        push(iType(OP_LW, 5'd0, 5'd5), stalls);
        push(rType(5'd5, 5'd1, 5'd6, FN_ADDU), stalls);
        present(NOP, hazardPkg::KCTRL_KTEXT);     // Load-use hazard pending in ID
        if (lastCtrl != FLUSH_CTRL) begin
            mismatch("flush controls", 32'(FLUSH_CTRL), 32'(lastCtrl));
        end
        pcVar = 32'h0000_4180;                    // Exception vector
        present(NOP, hazardPkg::KCTRL_NONE);
        if (lastMacro != lastFetchPc) begin
            mismatch("macroPc after flush", lastFetchPc, lastMacro);
        end
        drain(4);
        jalPc = pcVar;
        push({OP_JAL, 26'h000_0400}, stalls);
        drain(3);
        present(NOP, hazardPkg::KCTRL_NONE);      // JAL in WB, delay slot in MEM
        if (lastMacro != jalPc) begin
            mismatch("macroPc with JAL in WB", jalPc, lastMacro);
        end
        drain(2);
        endTest();
    endtask

    initial begin
        int unsigned seedDummy;
        seedDummy = $urandom(32'hd303_077d);
        rst <= 1'b1;
        fetchInstr <= NOP;
        fetchPc <= pcVar;
        kCtrlCp0 <= hazardPkg::KCTRL_NONE;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        resetTest();
        loadUseTest();
        branchTest();
        unrelatedTest();
        mulDivTest();
        flushTest();

        $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 testsRun, testsRun - testsFailed, testsFailed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/hazardPkg.sv
design/instrClassifier.sv
design/instrTiming.sv
design/stageTracker.sv
design/mulDivTracker.sv
design/pipelineControl.sv
design/hazardTop.sv
dv/hazardTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the hazard unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module hazardTb \
    --Mdir obj_dir -o hazardSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/hazardSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
